/* design/stream_pkg.sv */
package stream_pkg;

    // Width of one beat on every byte stream in the transmit path
    localparam int DATA_W = 8;

    // The patch buffer holds exactly one datagram, header included
    // 256 bytes leaves room for 248 payload bytes behind the 8-byte header
    localparam int FRAME_DEPTH = 256;

    // Address width of the patch buffer store
    localparam int ADDR_W = $clog2(FRAME_DEPTH);

endpackage

/* design/udp_pkg.sv */
package udp_pkg;

    // A UDP header is 8 bytes: src port, dst port, length, checksum
    localparam int UDP_HDR_BYTES = 8;

    // Byte offset of the length field, the checksum follows right behind it
    localparam int UDP_LEN_OFS = 4;

    // Fill values sent in the length and checksum fields before the patch buffer
    // overwrites them with the real numbers
    localparam logic [15:0] LEN_PLACEHOLDER  = 16'hBEEF;
    localparam logic [15:0] CSUM_PLACEHOLDER = 16'hDEAD;

    // Header request, src port sits in the upper half and goes out first
    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dst_port;
    } udp_ports_t;

    // Measured fields of one datagram, in header order
    typedef struct packed {
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_fields_t;

    // Queue depths for header requests and length/checksum results
    localparam int HDR_FIFO_DEPTH = 4;
    localparam int RES_FIFO_DEPTH = 2;

endpackage

/* design/sync_fifo.sv */
module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     i_clk,
    input  logic     i_reset_n,
    input  logic     push_valid,
    input  payload_t push_data,
    output logic     push_ready,
    output logic     pop_valid,
    output payload_t pop_data,
    input  logic     pop_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic             do_push;
    logic             do_pop;

    assign do_push = push_valid && push_ready;
    assign do_pop  = pop_valid && pop_ready;

    // The head entry is always presented, pop_valid follows the occupancy
    assign pop_valid = (count != '0);
    assign pop_data  = mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (do_push && !do_pop) begin
            count_next = count + 1'b1;
        end else if (do_pop && !do_push) begin
            count_next = count - 1'b1;
        end
    end

    // push_ready is registered so it stays low through reset and one cycle after
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            push_ready <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count      <= count_next;
            push_ready <= (count_next < CNT_W'(DEPTH));
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

/* design/udp_tx.sv */
module udp_tx (
    input  logic                          i_clk,
    input  logic                          i_reset_n,
    input  logic                          hdr_valid,
    input  udp_pkg::udp_ports_t           hdr_ports,
    output logic                          hdr_ready,
    input  logic [stream_pkg::DATA_W-1:0] s_data,
    input  logic                          s_valid,
    input  logic                          s_last,
    output logic                          s_ready,
    output logic [stream_pkg::DATA_W-1:0] enc_data,
    output logic                          enc_valid,
    output logic                          enc_last,
    input  logic                          enc_ready
);

    import stream_pkg::*;
    import udp_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HDR,
        ST_PAYLOAD
    } state_t;

    state_t                            state;
    udp_ports_t                        ports_q;
    logic [$clog2(UDP_HDR_BYTES)-1:0]  hdr_cnt;
    logic [UDP_HDR_BYTES*DATA_W-1:0]   hdr_bytes;
    logic [DATA_W-1:0]                 hdr_byte;
    logic                              load_ok;
    logic                              hdr_load;
    logic                              pay_load;

    // Whole header in wire order, first byte in the top bits
    assign hdr_bytes = {ports_q, LEN_PLACEHOLDER, CSUM_PLACEHOLDER};
    assign hdr_byte  = hdr_bytes[(UDP_HDR_BYTES - 1 - hdr_cnt) * DATA_W +: DATA_W];

    // The output register can take a new beat when empty or being emptied
    assign load_ok = !enc_valid || enc_ready;

    // A header is popped from the queue only while idle
    assign hdr_ready = (state == ST_IDLE);

    // Payload back-pressure is the output register's own state, no extra buffer
    assign s_ready  = (state == ST_PAYLOAD) && load_ok;
    assign hdr_load = (state == ST_HDR) && load_ok;
    assign pay_load = s_valid && s_ready;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state     <= ST_IDLE;
            hdr_cnt   <= '0;
            enc_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_valid) begin
                        state   <= ST_HDR;
                        hdr_cnt <= '0;
                    end
                end
                ST_HDR: begin
                    if (load_ok) begin
                        hdr_cnt <= hdr_cnt + 1'b1;
                        // Eighth header byte loaded, switch over to the payload
                        if (hdr_cnt == ($clog2(UDP_HDR_BYTES))'(UDP_HDR_BYTES - 1)) begin
                            state <= ST_PAYLOAD;
                        end
                    end
                end
                ST_PAYLOAD: begin
                    if (pay_load && s_last) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase

            if (hdr_load || pay_load) begin
                enc_valid <= 1'b1;
            end else if (enc_ready) begin
                enc_valid <= 1'b0;
            end
        end
    end

    // Header ports are latched at the pop so the queue can refill early
    always_ff @(posedge i_clk) begin
        if (state == ST_IDLE && hdr_valid) begin
            ports_q <= hdr_ports;
        end
        if (hdr_load) begin
            enc_data <= hdr_byte;
            enc_last <= 1'b0;
        end else if (pay_load) begin
            enc_data <= s_data;
            enc_last <= s_last;
        end
    end

endmodule

/* design/udp_len_csum.sv */
module udp_len_csum (
    input  logic                          i_clk,
    input  logic                          i_reset_n,
    input  logic [stream_pkg::DATA_W-1:0] enc_data,
    input  logic                          enc_valid,
    input  logic                          enc_last,
    input  logic                          enc_ready,
    output logic                          res_valid,
    output udp_pkg::udp_fields_t          res_fields
);

    import stream_pkg::*;
    import udp_pkg::*;

    logic              xfer;
    logic [15:0]       byte_cnt;
    logic              odd_q;
    logic [DATA_W-1:0] hi_q;
    logic [15:0]       sum_q;
    logic [DATA_W-1:0] byte_d;
    logic [15:0]       word;
    logic [15:0]       sum_word;
    logic [15:0]       len_next;
    logic [15:0]       sum_len;
    logic [15:0]       csum;

    // Ones-complement add, the carry out wraps back into bit 0
    function automatic logic [15:0] ones_add(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] full;
        full = {1'b0, a} + {1'b0, b};
        return full[15:0] + {15'd0, full[16]};
    endfunction

    // Only beats that really transfer are counted
    assign xfer = enc_valid && enc_ready;

    // Length and checksum bytes carry placeholders, so they count as zero here
    // The real length is added once at the end instead
    assign byte_d = (byte_cnt >= 16'(UDP_LEN_OFS) && byte_cnt < 16'(UDP_HDR_BYTES)) ?
                    '0 : enc_data;

    // On an even offset the byte is the high half, an odd final byte is padded low
    assign word     = odd_q ? {hi_q, byte_d} : {byte_d, 8'h00};
    assign sum_word = ones_add(sum_q, word);
    assign len_next = byte_cnt + 16'd1;
    assign sum_len  = ones_add(sum_word, len_next);

    // An all-zero result goes out as FFFF
    assign csum = (sum_len == 16'hFFFF) ? 16'hFFFF : ~sum_len;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            byte_cnt  <= '0;
            odd_q     <= 1'b0;
            sum_q     <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            if (xfer) begin
                if (enc_last) begin
                    // Next transfer starts a fresh datagram
                    byte_cnt  <= '0;
                    odd_q     <= 1'b0;
                    sum_q     <= '0;
                    res_valid <= 1'b1;
                end else begin
                    byte_cnt <= len_next;
                    odd_q    <= !odd_q;
                    if (odd_q) begin
                        sum_q <= sum_word;
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (xfer && !odd_q) begin
            hi_q <= byte_d;
        end
        if (xfer && enc_last) begin
            res_fields.length   <= len_next;
            res_fields.checksum <= csum;
        end
    end

endmodule

/* design/udp_frame_patch.sv */
module udp_frame_patch (
    input  logic                          i_clk,
    input  logic                          i_reset_n,
    input  logic [stream_pkg::DATA_W-1:0] enc_data,
    input  logic                          enc_valid,
    input  logic                          enc_last,
    output logic                          enc_ready,
    input  logic                          res_valid,
    input  udp_pkg::udp_fields_t          res_fields,
    output logic                          res_ready,
    output logic [stream_pkg::DATA_W-1:0] m_data,
    output logic                          m_valid,
    output logic                          m_last,
    input  logic                          m_ready
);

    import stream_pkg::*;
    import udp_pkg::*;

    typedef enum logic {
        ST_FILL,
        ST_DRAIN
    } state_t;

    state_t            state;
    logic [DATA_W-1:0] mem [FRAME_DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W-1:0] frame_last;
    logic              fill_xfer;
    logic              drain_load;
    logic              drain_end;
    logic [DATA_W-1:0] out_byte;

    // The store accepts beats only while filling, one per cycle
    assign enc_ready = (state == ST_FILL);
    assign fill_xfer = enc_valid && enc_ready;

    // Draining waits for the result, then loads the output register when free
    assign drain_load = (state == ST_DRAIN) && res_valid && (!m_valid || m_ready);
    assign drain_end  = drain_load && (rd_ptr == frame_last);

    // The result is retired together with the frame's last byte
    assign res_ready = drain_end;

    // Offsets 4 to 7 come from the measured fields, everything else from the store
    always_comb begin
        out_byte = mem[rd_ptr];
        if (rd_ptr >= ADDR_W'(UDP_LEN_OFS) && rd_ptr < ADDR_W'(UDP_HDR_BYTES)) begin
            out_byte = res_fields[(UDP_HDR_BYTES - 1 - rd_ptr) * DATA_W +: DATA_W];
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state   <= ST_FILL;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            m_valid <= 1'b0;
        end else begin
            case (state)
                ST_FILL: begin
                    if (fill_xfer) begin
                        wr_ptr <= wr_ptr + 1'b1;
                        if (enc_last) begin
                            // Whole datagram stored, hold the input off until it is out
                            state  <= ST_DRAIN;
                            wr_ptr <= '0;
                            rd_ptr <= '0;
                        end
                    end
                end
                ST_DRAIN: begin
                    if (drain_load) begin
                        rd_ptr <= rd_ptr + 1'b1;
                        if (drain_end) begin
                            state <= ST_FILL;
                        end
                    end
                end
                default: begin
                    state <= ST_FILL;
                end
            endcase

            if (drain_load) begin
                m_valid <= 1'b1;
            end else if (m_ready) begin
                m_valid <= 1'b0;
            end
        end
    end

    // The index of the last byte stands in for the frame length
    always_ff @(posedge i_clk) begin
        if (fill_xfer) begin
            mem[wr_ptr] <= enc_data;
            if (enc_last) begin
                frame_last <= wr_ptr;
            end
        end
        if (drain_load) begin
            m_data <= out_byte;
            m_last <= drain_end;
        end
    end

endmodule

/* design/udp_tx_subsys.sv */
module udp_tx_subsys (
    input  logic                          i_clk,
    input  logic                          i_reset_n,
    input  logic                          hdr_valid,
    input  logic [15:0]                   src_port,
    input  logic [15:0]                   dst_port,
    output logic                          hdr_ready,
    input  logic [stream_pkg::DATA_W-1:0] s_data,
    input  logic                          s_valid,
    input  logic                          s_last,
    output logic                          s_ready,
    output logic [stream_pkg::DATA_W-1:0] m_data,
    output logic                          m_valid,
    output logic                          m_last,
    input  logic                          m_ready
);

    import stream_pkg::*;
    import udp_pkg::*;

    // Queued header towards the encapsulator
    logic              hq_valid;
    logic              hq_ready;
    udp_ports_t        hq_ports;

    // Encapsulated stream, observed by the accumulator on its way to the buffer
    logic [DATA_W-1:0] enc_data;
    logic              enc_valid;
    logic              enc_last;
    logic              enc_ready;

    // Length and checksum results, before and after their queue
    logic              res_push_valid;
    udp_fields_t       res_push_fields;
    logic              res_valid;
    logic              res_ready;
    udp_fields_t       res_fields;

    sync_fifo #(
        .payload_t (udp_ports_t),
        .DEPTH     (HDR_FIFO_DEPTH)
    ) hdr_fifo (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .push_valid (hdr_valid),
        .push_data  (udp_ports_t'({src_port, dst_port})),
        .push_ready (hdr_ready),
        .pop_valid  (hq_valid),
        .pop_data   (hq_ports),
        .pop_ready  (hq_ready)
    );

    udp_tx u_udp_tx (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .hdr_valid (hq_valid),
        .hdr_ports (hq_ports),
        .hdr_ready (hq_ready),
        .s_data    (s_data),
        .s_valid   (s_valid),
        .s_last    (s_last),
        .s_ready   (s_ready),
        .enc_data  (enc_data),
        .enc_valid (enc_valid),
        .enc_last  (enc_last),
        .enc_ready (enc_ready)
    );

    udp_len_csum u_udp_len_csum (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .enc_data   (enc_data),
        .enc_valid  (enc_valid),
        .enc_last   (enc_last),
        .enc_ready  (enc_ready),
        .res_valid  (res_push_valid),
        .res_fields (res_push_fields)
    );

    // The buffer holds one frame, so at most one result ever waits here
    // and the push side never sees the queue full
    sync_fifo #(
        .payload_t (udp_fields_t),
        .DEPTH     (RES_FIFO_DEPTH)
    ) res_fifo (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .push_valid (res_push_valid),
        .push_data  (res_push_fields),
        .push_ready (),
        .pop_valid  (res_valid),
        .pop_data   (res_fields),
        .pop_ready  (res_ready)
    );

    udp_frame_patch u_udp_frame_patch (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .enc_data   (enc_data),
        .enc_valid  (enc_valid),
        .enc_last   (enc_last),
        .enc_ready  (enc_ready),
        .res_valid  (res_valid),
        .res_fields (res_fields),
        .res_ready  (res_ready),
        .m_data     (m_data),
        .m_valid    (m_valid),
        .m_last     (m_last),
        .m_ready    (m_ready)
    );

endmodule

/* verification/udp_tx_tb.sv */
module udp_tx_tb;

    import stream_pkg::*;
    import udp_pkg::*;

    // One row of the frame table holds ports, payload size, payload seed and output back-pressure
    typedef struct packed {
        logic [15:0] src;
        logic [15:0] dst;
        logic [7:0]  len;
        logic [31:0] seed;
        logic        bp;
    } frame_row_t;

    localparam int          N_ROWS     = 8;
    localparam logic [31:0] SEED       = 32'h2175;
    localparam int          WAIT_LIMIT = 2000;
    localparam int          DONE_LIMIT = 20000;

    // Rows 3 to 5 run back to back on headers that queue up while earlier frames drain
    localparam frame_row_t ROWS [N_ROWS] = '{
        '{16'h1234, 16'h0035, 8'd16,  32'h0000_0011, 1'b0},
        '{16'hC001, 16'h0277, 8'd7,   32'h0000_0022, 1'b0},
        '{16'h4000, 16'h8001, 8'd40,  32'h0000_0033, 1'b1},
        '{16'hABCD, 16'h0101, 8'd12,  32'h0000_0044, 1'b0},
        '{16'h0F0F, 16'hF0F0, 8'd5,   32'h0000_0055, 1'b1},
        '{16'h7FFF, 16'hFFFF, 8'd20,  32'h0000_0066, 1'b0},
        '{16'h0001, 16'h0002, 8'd1,   32'h0000_0077, 1'b0},
        '{16'hE000, 16'h1F00, 8'd248, 32'h0000_0088, 1'b1}
    };

    logic              i_clk = 1'b0;
    logic              i_reset_n;
    logic              hdr_valid;
    logic [15:0]       src_port;
    logic [15:0]       dst_port;
    logic              hdr_ready;
    logic [DATA_W-1:0] s_data;
    logic              s_valid;
    logic              s_last;
    logic              s_ready;
    logic [DATA_W-1:0] m_data;
    logic              m_valid;
    logic              m_last;
    logic              m_ready;

    // Reference queues are filled from the table before any stimulus starts
    logic [DATA_W-1:0] pay_q [$];
    logic [DATA_W-1:0] exp_bytes [$];
    logic              exp_last [$];
    udp_fields_t       exp_fields [$];

    logic [DATA_W-1:0] rx_buf [FRAME_DEPTH];
    int                rx_cnt      = 0;
    int                out_frame   = 0;
    int                err_cnt     = 0;
    int                proto_cnt   = 0;
    logic [31:0]       bp_rng      = SEED;
    logic              prev_stall  = 1'b0;
    logic [DATA_W-1:0] prev_data;
    logic              prev_last;

    udp_tx_subsys i_dut (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .hdr_valid (hdr_valid),
        .src_port  (src_port),
        .dst_port  (dst_port),
        .hdr_ready (hdr_ready),
        .s_data    (s_data),
        .s_valid   (s_valid),
        .s_last    (s_last),
        .s_ready   (s_ready),
        .m_data    (m_data),
        .m_valid   (m_valid),
        .m_last    (m_last),
        .m_ready   (m_ready)
    );

    always #2 i_clk = ~i_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_byte(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_fields(input string name, input udp_fields_t got,
                                input udp_fields_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout while waiting for %s at %0t", what, $time);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // Builds one expected datagram straight from the UDP header layout and checksum rule
    task automatic build_expected(input frame_row_t row);
        logic [DATA_W-1:0] frm [FRAME_DEPTH];
        logic [31:0]       rng;
        logic [31:0]       acc;
        logic [15:0]       total;
        logic [15:0]       csum;
        logic [DATA_W-1:0] lo;
        udp_fields_t       fld;
        int                i;
        int                n;
        n = int'(row.len) + UDP_HDR_BYTES;
        total = 16'(n);
        frm[0] = row.src[15:8];
        frm[1] = row.src[7:0];
        frm[2] = row.dst[15:8];
        frm[3] = row.dst[7:0];
        frm[4] = total[15:8];
        frm[5] = total[7:0];
        // The checksum field counts as zero in the sum
        frm[6] = 8'h00;
        frm[7] = 8'h00;
        rng = SEED ^ row.seed;
        for (i = 0; i < int'(row.len); i++) begin
            rng = lcg_next(rng);
            frm[UDP_HDR_BYTES + i] = rng[23:16];
            pay_q.push_back(rng[23:16]);
        end
        // The sum runs over big-endian 16-bit words and an odd last byte gets a zero low half
        acc = 32'h0;
        for (i = 0; i < n; i += 2) begin
            lo = (i + 1 < n) ? frm[i + 1] : 8'h00;
            acc = acc + {16'h0, frm[i], lo};
        end
        while (acc[31:16] != 16'h0) begin
            acc = {16'h0, acc[15:0]} + {16'h0, acc[31:16]};
        end
        csum = ~acc[15:0];
        if (csum == 16'h0000) begin
            csum = 16'hFFFF;
        end
        frm[6] = csum[15:8];
        frm[7] = csum[7:0];
        for (i = 0; i < n; i++) begin
            exp_bytes.push_back(frm[i]);
            exp_last.push_back(i == n - 1);
        end
        fld.length   = total;
        fld.checksum = csum;
        exp_fields.push_back(fld);
    endtask

    // Header requests are pushed as fast as the queue takes them, so they run ahead
    task automatic drive_headers;
        int r;
        int waited;
        for (r = 0; r < N_ROWS; r++) begin
            hdr_valid = 1'b1;
            src_port  = ROWS[r].src;
            dst_port  = ROWS[r].dst;
            waited    = 0;
            @(negedge i_clk);
            while (!hdr_ready) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    timeout_fail("hdr_ready");
                end
                @(negedge i_clk);
            end
            @(posedge i_clk);
            #1;
        end
        hdr_valid = 1'b0;
    endtask

    task automatic drive_payloads;
        int r;
        int i;
        int waited;
        for (r = 0; r < N_ROWS; r++) begin
            for (i = 0; i < int'(ROWS[r].len); i++) begin
                s_valid = 1'b1;
                s_data  = pay_q.pop_front();
                s_last  = (i == int'(ROWS[r].len) - 1);
                waited  = 0;
                @(negedge i_clk);
                while (!s_ready) begin
                    waited++;
                    if (waited > WAIT_LIMIT) begin
                        timeout_fail("s_ready");
                    end
                    @(negedge i_clk);
                end
                @(posedge i_clk);
                #1;
            end
        end
        s_valid = 1'b0;
        s_last  = 1'b0;
    endtask

    // Output back-pressure follows the row of the frame that is coming out
    initial begin
        m_ready = 1'b1;
        forever begin
            @(posedge i_clk);
            #1;
            if (out_frame < N_ROWS && ROWS[out_frame].bp) begin
                bp_rng  = lcg_next(bp_rng);
                m_ready = bp_rng[16];
            end else begin
                m_ready = 1'b1;
            end
        end
    end

    // Monitor samples half a cycle after the drive, where every signal is settled
    always @(negedge i_clk) begin
        if (i_reset_n) begin
            if (prev_stall && (!m_valid || m_data !== prev_data || m_last !== prev_last)) begin
                proto_cnt++;
                $display("Output stream changed while stalled at %0t", $time);
            end
            prev_stall = m_valid && !m_ready;
            prev_data  = m_data;
            prev_last  = m_last;
            if (m_valid && m_ready) begin
                if (exp_bytes.size() == 0) begin
                    proto_cnt++;
                    $display("Output byte %h arrived with nothing expected at %0t", m_data, $time);
                end else begin
                    check_byte("m_data", m_data, exp_bytes.pop_front());
                    check_last("m_last", m_last, exp_last.pop_front());
                    if (rx_cnt < FRAME_DEPTH) begin
                        rx_buf[rx_cnt] = m_data;
                    end
                    rx_cnt++;
                    if (m_last) begin
                        check_fields("udp_fields", udp_fields_t'({rx_buf[4], rx_buf[5],
                                     rx_buf[6], rx_buf[7]}), exp_fields.pop_front());
                        rx_cnt = 0;
                        out_frame++;
                    end
                end
            end
        end
    end

    initial begin
        int r;
        int waited;
        i_reset_n = 1'b0;
        hdr_valid = 1'b0;
        src_port  = 16'h0;
        dst_port  = 16'h0;
        s_data    = '0;
        s_valid   = 1'b0;
        s_last    = 1'b0;
        for (r = 0; r < N_ROWS; r++) begin
            build_expected(ROWS[r]);
        end
        // Handshake outputs stay low through reset and the first cycle after it
        repeat (4) begin
            @(posedge i_clk);
            #1;
            check_flag("m_valid", m_valid, 1'b0);
            check_flag("s_ready", s_ready, 1'b0);
            check_flag("hdr_ready", hdr_ready, 1'b0);
        end
        i_reset_n = 1'b1;
        @(negedge i_clk);
        check_flag("m_valid", m_valid, 1'b0);
        check_flag("s_ready", s_ready, 1'b0);
        check_flag("hdr_ready", hdr_ready, 1'b0);
        @(posedge i_clk);
        #1;
        fork
            drive_headers();
            drive_payloads();
        join
        waited = 0;
        while (out_frame < N_ROWS) begin
            waited++;
            if (waited > DONE_LIMIT) begin
                timeout_fail("the last output frame");
            end
            @(negedge i_clk);
        end
        repeat (10) @(negedge i_clk);
        if (exp_bytes.size() != 0) begin
            proto_cnt++;
            $display("%0d expected output bytes never came out", exp_bytes.size());
        end
        $display("Errors: %0d value mismatches, %0d protocol errors", err_cnt, proto_cnt);
        if (err_cnt == 0 && proto_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
design/stream_pkg.sv
design/udp_pkg.sv
design/sync_fifo.sv
design/udp_tx.sv
design/udp_len_csum.sv
design/udp_frame_patch.sv
design/udp_tx_subsys.sv
verification/udp_tx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f --top-module udp_tx_tb -o udp_tx_tb_sim

sim_out="$(./obj_dir/udp_tx_tb_sim)"
echo "$sim_out"

# The run passes only if the testbench printed the pass line
echo "$sim_out" | grep -qx "TEST RESULT: PASS"
